// File: hw/acc_consts.svh
`ifndef ACC_CONSTS_SVH
`define ACC_CONSTS_SVH

// Memory port widths.
`define ACC_ADDR_WIDTH 32
`define ACC_DATA_WIDTH 64
`define ACC_TAG_WIDTH 16

// Queue sizing.
`define ACC_QTD_WIDTH 16
`define ACC_MAX_OUTSTANDING 8

// Tag of the completion record write.
`define ACC_DONE_TAG {`ACC_TAG_WIDTH{1'b1}}

`endif

// File: hw/acc_pkg.sv
`include "acc_consts.svh"

package acc_pkg;

  typedef struct packed {
    logic [`ACC_ADDR_WIDTH-1:0] addr;
    logic [`ACC_TAG_WIDTH-1:0]  tag;
  } rd_req_t;

  typedef struct packed {
    logic [`ACC_DATA_WIDTH-1:0] data;
    logic [`ACC_ADDR_WIDTH-1:0] addr;
    logic [`ACC_TAG_WIDTH-1:0]  tag;
  } wr_req_t;

  // Tag is the line index, so responses may come back in any order.
  typedef struct packed {
    logic [`ACC_DATA_WIDTH-1:0] data;
    logic [`ACC_TAG_WIDTH-1:0]  tag;
  } rd_resp_t;

  typedef struct packed {
    logic [`ACC_ADDR_WIDTH-1:0] in_addr;
    logic [`ACC_QTD_WIDTH-1:0]  qtd;
    logic [`ACC_ADDR_WIDTH-1:0] out_addr;
  } acc_conf_t;

  typedef struct packed {
    logic                      busy;
    logic                      done;
    logic [`ACC_QTD_WIDTH-1:0] lines_written;
  } acc_status_t;

endpackage

// File: hw/queue_counter.sv
`timescale 1ns/1ps
`include "acc_consts.svh"

module queue_counter (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load,
  input  logic [`ACC_QTD_WIDTH-1:0] qtd,
  input  logic                      issue,
  input  logic                      line_out,
  input  logic                      wr_ack,
  output logic                      can_issue,
  output logic                      reads_left_zero,
  output logic                      all_acked,
  output logic [`ACC_QTD_WIDTH-1:0] lines_written
);

  localparam int CREDIT_W = $clog2(`ACC_MAX_OUTSTANDING) + 1;

  logic [`ACC_QTD_WIDTH-1:0] qtd_q;
  logic [`ACC_QTD_WIDTH-1:0] reads_left;
  logic [`ACC_QTD_WIDTH:0]   acks;
  logic [CREDIT_W-1:0]       credits;
  logic                      credit_ret;

  // Lines arriving after an accelerator reset hold no credit.
  assign credit_ret = line_out && (credits != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      qtd_q      <= '0;
      reads_left <= '0;
      credits    <= '0;
      acks       <= '0;
    end else if (load) begin
      qtd_q      <= qtd;
      reads_left <= qtd;
      credits    <= '0;
      acks       <= '0;
    end else begin
      if (issue)
        reads_left <= reads_left - 1'b1;
      if (issue && !credit_ret)
        credits <= credits + 1'b1;
      else if (!issue && credit_ret)
        credits <= credits - 1'b1;
      if (wr_ack)
        acks <= acks + 1'b1;
    end
  end

  assign reads_left_zero = (reads_left == '0);
  assign can_issue       = !reads_left_zero && (credits < CREDIT_W'(`ACC_MAX_OUTSTANDING));
  // Data acks first, then one more for the completion record.
  assign all_acked       = (acks == {1'b0, qtd_q} + 1'b1);
  assign lines_written   = (acks > {1'b0, qtd_q}) ? qtd_q : acks[`ACC_QTD_WIDTH-1:0];

  a_credit_limit: assert property (@(posedge clk) disable iff (rst)
    credits <= CREDIT_W'(`ACC_MAX_OUTSTANDING));

endmodule

// File: hw/req_arbiter.sv
`timescale 1ns/1ps

module req_arbiter #(
  parameter type payload_t = logic [31:0],
  parameter int  NUM_IN    = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [NUM_IN-1:0]     en_in,
  input  payload_t [NUM_IN-1:0] data_in,
  output logic [NUM_IN-1:0]     available_in,
  output logic                  en_out,
  output payload_t              data_out,
  input  logic                  available_out
);

  localparam int PTR_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

  logic [NUM_IN-1:0] full;
  payload_t          buf_data [NUM_IN];
  logic [NUM_IN-1:0] gnt;
  logic [PTR_W-1:0]  gnt_idx;
  logic [PTR_W-1:0]  rr_ptr;

  // Search starts at the input after the last winner.
  always_comb begin
    int idx;
    gnt     = '0;
    gnt_idx = '0;
    for (int k = 0; k < NUM_IN; k++) begin
      idx = (int'(rr_ptr) + k) % NUM_IN;
      if (available_out && full[idx] && (gnt == '0)) begin
        gnt[idx] = 1'b1;
        gnt_idx  = PTR_W'(idx);
      end
    end
  end

  // ========================================
  // Input buffers, one entry each.
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      full <= '0;
    end else begin
      for (int i = 0; i < NUM_IN; i++) begin
        if (en_in[i])
          full[i] <= 1'b1;
        else if (gnt[i])
          full[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_IN; i++) begin
      if (en_in[i])
        buf_data[i] <= data_in[i];
    end
  end

  // High only when the buffer is sure to be empty next cycle.
  assign available_in = ~((full & ~gnt) | en_in);

  // ========================================
  // Registered output stage.
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      en_out <= 1'b0;
      rr_ptr <= '0;
    end else begin
      en_out <= |gnt;
      if (|gnt)
        rr_ptr <= (gnt_idx == PTR_W'(NUM_IN - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (|gnt)
      data_out <= buf_data[gnt_idx];
  end

  // Requesters must wait for available, so a held entry is never overwritten.
  a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
    (en_in & full & ~gnt) == '0);

endmodule

// File: hw/acc_datapath.sv
`timescale 1ns/1ps
`include "acc_consts.svh"

module acc_datapath (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       clear,
  input  logic                       resp_valid,
  input  acc_pkg::rd_resp_t          resp,
  input  logic [`ACC_ADDR_WIDTH-1:0] out_addr,
  output logic                       wr_en,
  output acc_pkg::wr_req_t           wr_req,
  input  logic                       wr_available,
  output logic                       line_out,
  output logic [`ACC_DATA_WIDTH-1:0] checksum
);

  localparam int DEPTH = `ACC_MAX_OUTSTANDING;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  acc_pkg::rd_resp_t mem [DEPTH];
  acc_pkg::rd_resp_t head;
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              empty;
  logic              full;
  logic              avail_q;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign head  = mem[rd_ptr];

  // Pop when the write arbiter offered space last cycle.
  assign wr_en    = !empty && avail_q;
  assign line_out = wr_en;

  // Output line goes to the same index in the output queue.
  assign wr_req.data = head.data;
  assign wr_req.addr = out_addr + (`ACC_ADDR_WIDTH'(head.tag) << 3);
  assign wr_req.tag  = head.tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      avail_q <= 1'b0;
    end else begin
      avail_q <= wr_available;
      if (resp_valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (wr_en)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + CNT_W'(resp_valid) - CNT_W'(wr_en);
    end
  end

  always_ff @(posedge clk) begin
    if (resp_valid)
      mem[wr_ptr] <= resp;
  end

  always_ff @(posedge clk) begin
    if (rst || clear)
      checksum <= '0;
    else if (resp_valid)
      checksum <= checksum ^ resp.data;
  end

  // Read credits bound the lines in flight to the FIFO depth.
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) resp_valid |-> !full);

endmodule

// File: hw/acc_ctrl.sv
`timescale 1ns/1ps
`include "acc_consts.svh"

module acc_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic [1:0]                 conf_valid,
  input  acc_pkg::acc_conf_t         conf,
  output logic                       rd_en,
  output acc_pkg::rd_req_t           rd_req,
  input  logic                       rd_available,
  output logic                       done_en,
  output acc_pkg::wr_req_t           done_req,
  input  logic                       done_available,
  output logic                       issue,
  input  logic                       can_issue,
  input  logic                       reads_left_zero,
  input  logic                       all_acked,
  input  logic [`ACC_DATA_WIDTH-1:0] checksum,
  output logic [`ACC_ADDR_WIDTH-1:0] out_addr,
  output acc_pkg::acc_status_t       status,
  input  logic [`ACC_QTD_WIDTH-1:0]  lines_written
);

  typedef enum logic [2:0] {
    st_idle, st_read, st_drain, st_record, st_wait_ack, st_done
  } state_t;

  state_t                     state;
  logic [`ACC_ADDR_WIDTH-1:0] in_addr;
  logic [`ACC_QTD_WIDTH-1:0]  qtd;
  logic [`ACC_QTD_WIDTH-1:0]  idx;
  logic                       rd_avail_q;
  logic                       done_avail_q;
  logic                       settled;

  // Configuration is accepted only between runs.
  assign settled = (state == st_idle) || (state == st_done);

  always_ff @(posedge clk) begin
    if (settled && conf_valid[0]) begin
      in_addr <= conf.in_addr;
      qtd     <= conf.qtd;
    end
    if (settled && conf_valid[1])
      out_addr <= conf.out_addr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_avail_q   <= 1'b0;
      done_avail_q <= 1'b0;
    end else begin
      rd_avail_q   <= rd_available;
      done_avail_q <= done_available;
    end
  end

  // ========================================
  // Sequencer.
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      idx   <= '0;
    end else begin
      case (state)
        st_idle, st_done: begin
          if (start) begin
            state <= st_read;
            idx   <= '0;
          end
        end
        st_read: begin
          if (rd_en)
            idx <= idx + 1'b1;
          if (reads_left_zero)
            state <= st_drain;
        end
        // Record waits for every data ack so it lands after the last line.
        st_drain:    if (lines_written == qtd) state <= st_record;
        st_record:   if (done_en) state <= st_wait_ack;
        st_wait_ack: if (all_acked) state <= st_done;
        default:     state <= st_idle;
      endcase
    end
  end

  assign rd_en       = (state == st_read) && rd_avail_q && can_issue;
  assign issue       = rd_en;
  assign rd_req.addr = in_addr + (`ACC_ADDR_WIDTH'(idx) << 3);
  assign rd_req.tag  = `ACC_TAG_WIDTH'(idx);

  assign done_en       = (state == st_record) && done_avail_q;
  assign done_req.data = checksum;
  assign done_req.addr = out_addr + (`ACC_ADDR_WIDTH'(qtd) << 3);
  assign done_req.tag  = `ACC_DONE_TAG;

  assign status.busy          = !settled;
  assign status.done          = (state == st_done);
  assign status.lines_written = lines_written;

  a_rd_in_read: assert property (@(posedge clk) disable iff (rst)
    rd_en |-> (state == st_read) && !reads_left_zero);

endmodule

// File: hw/acc_mgmt.sv
`timescale 1ns/1ps
`include "acc_consts.svh"

module acc_mgmt (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      acc_rst,
  input  logic                      start,
  input  logic [1:0]                conf_valid,
  input  acc_pkg::acc_conf_t        conf,
  output logic                      req_rd_en,
  output acc_pkg::rd_req_t          req_rd,
  input  logic                      req_rd_available,
  input  logic                      resp_rd_valid,
  input  acc_pkg::rd_resp_t         resp_rd,
  output logic                      req_wr_en,
  output acc_pkg::wr_req_t          req_wr,
  input  logic                      req_wr_available,
  input  logic                      resp_wr_valid,
  input  logic [`ACC_TAG_WIDTH-1:0] resp_wr_tag,
  output acc_pkg::acc_status_t      info
);

  logic                       acc_rst_all;
  logic                       conf_load;
  logic                       ctrl_rd_en;
  acc_pkg::rd_req_t           ctrl_rd_req;
  logic                       ctrl_rd_avail;
  logic                       ctrl_done_en;
  acc_pkg::wr_req_t           ctrl_done_req;
  logic                       dp_wr_en;
  acc_pkg::wr_req_t           dp_wr_req;
  logic [1:0]                 wr_avail_in;
  logic                       issue;
  logic                       line_out;
  logic                       can_issue;
  logic                       reads_left_zero;
  logic                       all_acked;
  logic [`ACC_QTD_WIDTH-1:0]  lines_written;
  logic [`ACC_DATA_WIDTH-1:0] checksum;
  logic [`ACC_ADDR_WIDTH-1:0] out_addr;

  assign acc_rst_all = rst | acc_rst;
  assign conf_load   = conf_valid[0] & ~info.busy;

  acc_ctrl u_ctrl (
    .clk(clk), .rst(acc_rst_all), .start(start), .conf_valid(conf_valid), .conf(conf),
    .rd_en(ctrl_rd_en), .rd_req(ctrl_rd_req), .rd_available(ctrl_rd_avail),
    .done_en(ctrl_done_en), .done_req(ctrl_done_req), .done_available(wr_avail_in[1]),
    .issue(issue), .can_issue(can_issue), .reads_left_zero(reads_left_zero),
    .all_acked(all_acked), .checksum(checksum), .out_addr(out_addr),
    .status(info), .lines_written(lines_written)
  );

  queue_counter u_counter (
    .clk(clk), .rst(acc_rst_all), .load(conf_load), .qtd(conf.qtd),
    .issue(issue), .line_out(line_out), .wr_ack(resp_wr_valid),
    .can_issue(can_issue), .reads_left_zero(reads_left_zero),
    .all_acked(all_acked), .lines_written(lines_written)
  );

  acc_datapath u_datapath (
    .clk(clk), .rst(acc_rst_all), .clear(conf_load),
    .resp_valid(resp_rd_valid), .resp(resp_rd), .out_addr(out_addr),
    .wr_en(dp_wr_en), .wr_req(dp_wr_req), .wr_available(wr_avail_in[0]),
    .line_out(line_out), .checksum(checksum)
  );

  // Arbiters see only the port reset so queued requests still go out.
  req_arbiter #(.payload_t(acc_pkg::rd_req_t), .NUM_IN(1)) u_rd_arb (
    .clk(clk), .rst(rst),
    .en_in(ctrl_rd_en), .data_in(ctrl_rd_req), .available_in(ctrl_rd_avail),
    .en_out(req_rd_en), .data_out(req_rd), .available_out(req_rd_available)
  );

  req_arbiter #(.payload_t(acc_pkg::wr_req_t), .NUM_IN(2)) u_wr_arb (
    .clk(clk), .rst(rst),
    .en_in({ctrl_done_en, dp_wr_en}), .data_in({ctrl_done_req, dp_wr_req}),
    .available_in(wr_avail_in),
    .en_out(req_wr_en), .data_out(req_wr), .available_out(req_wr_available)
  );

  // Completion record is acknowledged while the run is still open.
  a_record_ack: assert property (@(posedge clk) disable iff (acc_rst_all)
    resp_wr_valid && (resp_wr_tag == `ACC_DONE_TAG) |-> info.busy);

endmodule

// File: testbench/tb_acc_mgmt.sv
`timescale 1ns/1ps
`include "acc_consts.svh"

module tb_acc_mgmt;

  localparam int RUN_CYCLES = (1 + 16 + 40 + 12 + 40) * 200;
  localparam logic [63:0] PATTERN_KEY = 64'hC3A5_96E1_0F5A_7B2D;

  logic clk = 1'b0;
  logic rst, acc_rst, start;
  logic [1:0] conf_valid;
  acc_pkg::acc_conf_t conf;
  logic req_rd_en, req_rd_available, resp_rd_valid;
  acc_pkg::rd_req_t req_rd;
  acc_pkg::rd_resp_t resp_rd;
  logic req_wr_en, req_wr_available, resp_wr_valid;
  acc_pkg::wr_req_t req_wr;
  logic [`ACC_TAG_WIDTH-1:0] resp_wr_tag;
  acc_pkg::acc_status_t info;

  acc_mgmt uut (
    .clk(clk), .rst(rst), .acc_rst(acc_rst), .start(start), .conf_valid(conf_valid),
    .conf(conf), .req_rd_en(req_rd_en), .req_rd(req_rd), .req_rd_available(req_rd_available),
    .resp_rd_valid(resp_rd_valid), .resp_rd(resp_rd), .req_wr_en(req_wr_en), .req_wr(req_wr),
    .req_wr_available(req_wr_available), .resp_wr_valid(resp_wr_valid),
    .resp_wr_tag(resp_wr_tag), .info(info)
  );

  acc_pkg::rd_req_t rd_q [$];
  int rd_due [$];
  logic [`ACC_TAG_WIDTH-1:0] ack_q [$];
  int ack_due [$];
  int cyc = 0, errors = 0, checks = 0, tests = 0;
  int data_writes, done_writes;
  bit rand_avail = 1'b0, checking = 1'b0;
  bit seen [64];
  logic [`ACC_ADDR_WIDTH-1:0] in_base, out_base;
  logic [`ACC_QTD_WIDTH-1:0] cur_qtd;
  logic [`ACC_DATA_WIDTH-1:0] exp_sum;

  always #20 clk = ~clk;

  function automatic logic [63:0] line_pattern(input logic [31:0] addr);
    return {addr, ~addr} ^ PATTERN_KEY;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s (at %0t)", msg, $time);
    errors++;
  endtask

  task automatic check_write(input acc_pkg::wr_req_t w);
    logic [31:0] exp_addr;
    logic [63:0] exp_data;
    if (!checking)
      return;
    checks++;
    if (w.tag == `ACC_DONE_TAG) begin
      exp_addr = out_base + {cur_qtd, 3'b000};
      assert (w.addr == exp_addr && w.data == exp_sum)
        else report_mismatch($sformatf("record addr %h data %h", w.addr, w.data));
      assert (data_writes == int'(cur_qtd) && done_writes == 0)
        else report_failure("completion record came early or more than once");
      done_writes++;
    end else begin
      assert (w.tag < cur_qtd && !seen[w.tag[5:0]])
        else report_failure($sformatf("line %0d written twice or outside the queue", w.tag));
      exp_addr = out_base + {w.tag, 3'b000};
      exp_data = line_pattern(in_base + {w.tag, 3'b000});
      assert (w.addr == exp_addr && w.data == exp_data)
        else report_mismatch($sformatf("line %0d addr %h data %h", w.tag, w.addr, w.data));
      seen[w.tag[5:0]] = 1'b1;
      data_writes++;
    end
  endtask

  // ========================================
  // Memory model with random latency.
  // ========================================
  always @(negedge clk) begin : memory_model
    int pick;
    int ack_pick;
    cyc++;
    if (rst) begin
      resp_rd_valid    = 1'b0;
      resp_wr_valid    = 1'b0;
      req_rd_available = 1'b1;
      req_wr_available = 1'b1;
    end else begin
      // Availability seen here is what the DUT sampled one cycle back.
      assert (!req_rd_en || req_rd_available)
        else report_failure("read request sent without available in the cycle before");
      assert (!req_wr_en || req_wr_available)
        else report_failure("write request sent without available in the cycle before");
      assert (rd_q.size() < `ACC_MAX_OUTSTANDING + 2)
        else report_failure("too many reads left unanswered");
      assert (!(checking && info.done) || done_writes == 1)
        else report_failure("done rose before the completion record");
      if (req_rd_en) begin
        rd_q.push_back(req_rd);
        rd_due.push_back(cyc + int'($urandom_range(6, 1)));
      end
      if (req_wr_en) begin
        check_write(req_wr);
        ack_q.push_back(req_wr.tag);
        ack_due.push_back(cyc + int'($urandom_range(6, 1)));
      end
      pick = -1;
      foreach (rd_due[i])
        if (pick < 0 && rd_due[i] <= cyc)
          pick = i;
      resp_rd_valid = (pick >= 0);
      if (pick >= 0) begin
        resp_rd.tag  = rd_q[pick].tag;
        resp_rd.data = line_pattern(rd_q[pick].addr);
        rd_q.delete(pick);
        rd_due.delete(pick);
      end
      ack_pick = -1;
      foreach (ack_due[i])
        if (ack_pick < 0 && ack_due[i] <= cyc)
          ack_pick = i;
      resp_wr_valid = (ack_pick >= 0);
      if (ack_pick >= 0) begin
        resp_wr_tag = ack_q[ack_pick];
        ack_q.delete(ack_pick);
        ack_due.delete(ack_pick);
      end
      req_rd_available = rand_avail ? ($urandom_range(3, 0) != 0) : 1'b1;
      req_wr_available = rand_avail ? ($urandom_range(3, 0) != 0) : 1'b1;
    end
  end

  task automatic begin_run(input logic [31:0] ib, ob, input logic [15:0] n, input bit rnd);
    rand_avail = rnd;
    in_base    = ib;
    out_base   = ob;
    cur_qtd    = n;
    exp_sum    = '0;
    for (int i = 0; i < int'(n); i++)
      exp_sum = exp_sum ^ line_pattern(ib + 32'(i * 8));
    foreach (seen[i])
      seen[i] = 1'b0;
    data_writes    = 0;
    done_writes    = 0;
    conf.in_addr   = ib;
    conf.qtd       = n;
    conf.out_addr  = ob;
    conf_valid     = 2'b11;
    @(negedge clk);
    conf_valid = 2'b00;
    start      = 1'b1;
    @(negedge clk);
    start    = 1'b0;
    checking = 1'b1;
  endtask

  task automatic run_queue(input string name, input logic [31:0] ib, ob,
                           input logic [15:0] n, input bit rnd);
    int errs_before;
    errs_before = errors;
    begin_run(ib, ob, n, rnd);
    while (!info.done)
      @(negedge clk);
    assert (data_writes == int'(n) && done_writes == 1 && !info.busy)
      else report_failure("run ended without every line and one completion record");
    assert (info.lines_written == n)
      else report_mismatch($sformatf("lines_written %0d, expected %0d",
                                     info.lines_written, n));
    checking = 1'b0;
    tests++;
    $display("test %s: %0d lines, %0d errors", name, n, errors - errs_before);
  endtask

  // Abort part way, then wait until the in-flight traffic dies out.
  task automatic abort_run();
    int errs_before;
    int idle;
    errs_before = errors;
    begin_run(32'h0004_0000, 32'h0005_0000, 16'd40, 1'b1);
    while (data_writes < 10)
      @(negedge clk);
    checking = 1'b0;
    acc_rst  = 1'b1;
    @(negedge clk);
    acc_rst = 1'b0;
    assert (!info.busy && !info.done)
      else report_failure("status not cleared by the accelerator reset");
    idle = 0;
    while (idle < 30) begin
      @(negedge clk);
      if (req_rd_en || req_wr_en || rd_q.size() != 0 || ack_q.size() != 0)
        idle = 0;
      else
        idle++;
    end
    tests++;
    $display("test reset_state: %0d errors", errors - errs_before);
  endtask

  initial begin
    void'($urandom(60));
    rst              = 1'b1;
    acc_rst          = 1'b0;
    start            = 1'b0;
    conf_valid       = 2'b00;
    conf             = '0;
    req_rd_available = 1'b0;
    req_wr_available = 1'b0;
    resp_rd_valid    = 1'b0;
    resp_rd          = '0;
    resp_wr_valid    = 1'b0;
    resp_wr_tag      = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    assert (!info.busy && !info.done) else report_failure("status not clear after reset");
    run_queue("copy_qtd1", 32'h0000_1000, 32'h0000_8000, 16'd1, 1'b0);
    run_queue("backpressure_qtd16", 32'h0001_0000, 32'h0002_0000, 16'd16, 1'b1);
    abort_run();
    run_queue("restart_qtd12", 32'h0006_0040, 32'h0007_0000, 16'd12, 1'b1);
    run_queue("size_qtd40", 32'h0008_0000, 32'h0009_0100, 16'd40, 1'b1);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  initial begin : watchdog
    repeat (RUN_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", RUN_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: acc_mgmt.f
+incdir+hw
hw/acc_pkg.sv
hw/queue_counter.sv
hw/req_arbiter.sv
hw/acc_datapath.sv
hw/acc_ctrl.sv
hw/acc_mgmt.sv
testbench/tb_acc_mgmt.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_acc_mgmt
FLIST     ?= acc_mgmt.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
